/* wb_bus_pkg.sv */
package wb_bus_pkg;

  localparam int ADR_W = 32;
  localparam int DAT_W = 16;
  localparam int SEL_W = 2;

  // Derived sizes of one byte lane and of the byte offset within a word
  localparam int BYTE_W = DAT_W / SEL_W;
  localparam int ADR_LSB = $clog2(SEL_W);

  // Replace only the byte lanes whose select bit is high
  function automatic logic [DAT_W-1:0] merge_lanes(input logic [DAT_W-1:0] old_word,
                                                   input logic [DAT_W-1:0] new_word,
                                                   input logic [SEL_W-1:0] sel);
    merge_lanes = old_word;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        merge_lanes[b*BYTE_W +: BYTE_W] = new_word[b*BYTE_W +: BYTE_W];
      end
    end
  endfunction

endpackage

/* wb_map_pkg.sv */
package wb_map_pkg;

  // Address regions are matched on the bits above the span
  localparam logic [wb_bus_pkg::ADR_W-1:0] SRAM_BASE = 32'h0000_0000;
  localparam int SRAM_SPAN_BITS = 10;
  localparam logic [wb_bus_pkg::ADR_W-1:0] REG_BASE = 32'h0001_0000;
  localparam int REG_SPAN_BITS = 3;

  localparam int NUM_SLAVES = 2;
  localparam int SLV_W = $clog2(NUM_SLAVES);
  localparam logic [SLV_W-1:0] SLV_SRAM = 1'd0;
  localparam logic [SLV_W-1:0] SLV_REG = 1'd1;

  // Register block layout in word offsets inside the region
  localparam int REG_OFS_W = REG_SPAN_BITS - wb_bus_pkg::ADR_LSB;
  localparam logic [REG_OFS_W-1:0] REG_SCRATCH0 = 2'd0;
  localparam logic [REG_OFS_W-1:0] REG_SCRATCH1 = 2'd1;
  localparam logic [REG_OFS_W-1:0] REG_WCOUNT = 2'd2;
  localparam logic [REG_OFS_W-1:0] REG_ID = 2'd3;

  localparam logic [wb_bus_pkg::DAT_W-1:0] ID_VALUE = 16'hB0C5;

endpackage

/* wbm_arbiter.sv */
`timescale 1ns/10ps

module wbm_arbiter #(
  parameter int NUM_MASTERS = 4,
  localparam int ID_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1
) (
  input  logic                                       wb_clk_i,
  input  logic                                       wb_rst_i,
  // Master side
  input  logic [NUM_MASTERS-1:0]                     wbm_cyc_i,
  input  logic [NUM_MASTERS-1:0]                     wbm_stb_i,
  input  logic [NUM_MASTERS-1:0]                     wbm_we_i,
  input  logic [NUM_MASTERS*wb_bus_pkg::SEL_W-1:0]   wbm_sel_i,
  input  logic [NUM_MASTERS*wb_bus_pkg::ADR_W-1:0]   wbm_adr_i,
  input  logic [NUM_MASTERS*wb_bus_pkg::DAT_W-1:0]   wbm_dat_i,
  input  logic [NUM_MASTERS-1:0]                     wbm_mask_i,
  output logic [wb_bus_pkg::DAT_W-1:0]               wbm_dat_o,
  output logic [NUM_MASTERS-1:0]                     wbm_ack_o,
  output logic [NUM_MASTERS-1:0]                     wbm_err_o,
  output logic [ID_W-1:0]                            wbm_id_o,
  // Shared bus toward the decoder and slaves
  output logic                                       bus_stb_o,
  output logic                                       bus_we_o,
  output logic [wb_bus_pkg::SEL_W-1:0]               bus_sel_o,
  output logic [wb_bus_pkg::ADR_W-1:0]               bus_adr_o,
  output logic [wb_bus_pkg::DAT_W-1:0]               bus_dat_o,
  // Response from the slave side
  input  logic                                       rsp_ack_i,
  input  logic                                       rsp_err_i,
  input  logic [wb_bus_pkg::DAT_W-1:0]               rsp_dat_i
);

  import wb_bus_pkg::*;

  logic [NUM_MASTERS-1:0] pending;
  logic                   busy;
  logic [ID_W-1:0]        active_master;

  // Highest-numbered pending master wins
  function automatic logic [ID_W-1:0] pick_master(input logic [NUM_MASTERS-1:0] req);
    pick_master = '0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (req[m]) begin
        pick_master = ID_W'(m);
      end
    end
  endfunction

  // ----------------------------------------
  // Request capture and grant
  // ----------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending       <= '0;
      busy          <= 1'b0;
      active_master <= ID_W'(1);
      bus_stb_o     <= 1'b0;
    end else begin
      bus_stb_o <= 1'b0;
      pending   <= pending | (wbm_cyc_i & wbm_stb_i & wbm_mask_i);

      // The response clears the active bit even if its strobe is still up
      if (rsp_ack_i || rsp_err_i) begin
        pending[active_master] <= 1'b0;
        busy                   <= 1'b0;
      end

      if (!busy && |pending) begin
        bus_stb_o     <= 1'b1;
        busy          <= 1'b1;
        active_master <= pick_master(pending);
      end
    end
  end

  // ----------------------------------------
  // Routing of the granted master
  // ----------------------------------------
  assign bus_we_o  = wbm_we_i[active_master];
  assign bus_sel_o = wbm_sel_i[active_master*SEL_W +: SEL_W];
  assign bus_adr_o = wbm_adr_i[active_master*ADR_W +: ADR_W];
  assign bus_dat_o = wbm_dat_i[active_master*DAT_W +: DAT_W];

  assign wbm_id_o  = active_master;
  assign wbm_dat_o = rsp_dat_i;

  always_comb begin
    wbm_ack_o = '0;
    wbm_err_o = '0;
    wbm_ack_o[active_master] = rsp_ack_i;
    wbm_err_o[active_master] = rsp_err_i;
  end

endmodule

/* wbs_addr_decoder.sv */
`timescale 1ns/10ps

module wbs_addr_decoder (
  input  logic                             wb_clk_i,
  input  logic                             wb_rst_i,
  input  logic                             bus_stb_i,
  input  logic [wb_bus_pkg::ADR_W-1:0]     bus_adr_i,
  output logic                             sram_stb_o,
  output logic                             reg_stb_o,
  output logic [wb_map_pkg::SLV_W-1:0]     resp_slave_o,
  output logic                             dec_err_o
);

  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  logic sram_hit;
  logic reg_hit;

  // Region match on the address bits above each span
  assign sram_hit = (bus_adr_i[ADR_W-1:SRAM_SPAN_BITS] == SRAM_BASE[ADR_W-1:SRAM_SPAN_BITS]);
  assign reg_hit  = (bus_adr_i[ADR_W-1:REG_SPAN_BITS] == REG_BASE[ADR_W-1:REG_SPAN_BITS]);

  // Strobes pass through in the same cycle
  assign sram_stb_o = bus_stb_i && sram_hit;
  assign reg_stb_o  = bus_stb_i && reg_hit;

  // ----------------------------------------
  // Held slave index and error pulse
  // ----------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      resp_slave_o <= SLV_SRAM;
      dec_err_o    <= 1'b0;
    end else begin
      // Unmapped address is answered one cycle after its strobe
      dec_err_o <= bus_stb_i && !sram_hit && !reg_hit;
      if (bus_stb_i) begin
        resp_slave_o <= reg_hit ? SLV_REG : SLV_SRAM;
      end
    end
  end

endmodule

/* wbs_sram.sv */
`timescale 1ns/10ps

module wbs_sram #(
  parameter int SRAM_DEPTH = 256
) (
  input  logic                           wb_clk_i,
  input  logic                           wb_rst_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [wb_bus_pkg::SEL_W-1:0]   sel_i,
  input  logic [wb_bus_pkg::ADR_W-1:0]   adr_i,
  input  logic [wb_bus_pkg::DAT_W-1:0]   dat_i,
  output logic                           ack_o,
  output logic [wb_bus_pkg::DAT_W-1:0]   dat_o
);

  import wb_bus_pkg::*;

  localparam int AW = $clog2(SRAM_DEPTH);

  logic [DAT_W-1:0] mem [SRAM_DEPTH];
  logic [AW-1:0]    word_idx;

  // Word index starts above the byte offset
  assign word_idx = adr_i[ADR_LSB +: AW];

  always_ff @(posedge wb_clk_i) begin
    if (stb_i) begin
      if (we_i) begin
        mem[word_idx] <= merge_lanes(mem[word_idx], dat_i, sel_i);
      end else begin
        dat_o <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i;
    end
  end

endmodule

/* wbs_regfile.sv */
`timescale 1ns/10ps

module wbs_regfile (
  input  logic                           wb_clk_i,
  input  logic                           wb_rst_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [wb_bus_pkg::SEL_W-1:0]   sel_i,
  input  logic [wb_bus_pkg::ADR_W-1:0]   adr_i,
  input  logic [wb_bus_pkg::DAT_W-1:0]   dat_i,
  output logic                           ack_o,
  output logic [wb_bus_pkg::DAT_W-1:0]   dat_o
);

  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  logic [REG_OFS_W-1:0] reg_ofs;
  logic [DAT_W-1:0]     scratch0;
  logic [DAT_W-1:0]     scratch1;
  logic [DAT_W-1:0]     wcount;

  assign reg_ofs = adr_i[ADR_LSB +: REG_OFS_W];

  // ----------------------------------------
  // Writes and the write counter
  // ----------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      scratch0 <= '0;
      scratch1 <= '0;
      wcount   <= '0;
      ack_o    <= 1'b0;
    end else begin
      ack_o <= stb_i;
      if (stb_i && we_i) begin
        // Every write is counted including those to read-only targets
        wcount <= wcount + 1'b1;
        case (reg_ofs)
          REG_SCRATCH0: scratch0 <= merge_lanes(scratch0, dat_i, sel_i);
          REG_SCRATCH1: scratch1 <= merge_lanes(scratch1, dat_i, sel_i);
          default: ;
        endcase
      end
    end
  end

  // Read data is registered with the strobe
  always_ff @(posedge wb_clk_i) begin
    if (stb_i && !we_i) begin
      case (reg_ofs)
        REG_SCRATCH0: dat_o <= scratch0;
        REG_SCRATCH1: dat_o <= scratch1;
        REG_WCOUNT:   dat_o <= wcount;
        REG_ID:       dat_o <= ID_VALUE;
        default:      dat_o <= '0;
      endcase
    end
  end

endmodule

/* wbs_resp_mux.sv */
`timescale 1ns/10ps

module wbs_resp_mux (
  input  logic [wb_map_pkg::SLV_W-1:0]   resp_slave_i,
  input  logic                           dec_err_i,
  input  logic                           sram_ack_i,
  input  logic [wb_bus_pkg::DAT_W-1:0]   sram_dat_i,
  input  logic                           reg_ack_i,
  input  logic [wb_bus_pkg::DAT_W-1:0]   reg_dat_i,
  output logic                           rsp_ack_o,
  output logic                           rsp_err_o,
  output logic [wb_bus_pkg::DAT_W-1:0]   rsp_dat_o
);

  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  logic [DAT_W-1:0] sel_dat;

  always_comb begin
    case (resp_slave_i)
      SLV_REG: begin
        rsp_ack_o = reg_ack_i;
        sel_dat   = reg_dat_i;
      end
      default: begin
        rsp_ack_o = sram_ack_i;
        sel_dat   = sram_dat_i;
      end
    endcase
  end

  // Data stays at zero between responses
  assign rsp_dat_o = rsp_ack_o ? sel_dat : '0;
  assign rsp_err_o = dec_err_i;

endmodule

/* wb_subsys_top.sv */
`timescale 1ns/10ps

module wb_subsys_top #(
  parameter int NUM_MASTERS = 4,
  parameter int SRAM_DEPTH = 256,
  localparam int ID_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1
) (
  input  logic                                       wb_clk_i,
  input  logic                                       wb_rst_i,
  input  logic [NUM_MASTERS-1:0]                     wbm_cyc_i,
  input  logic [NUM_MASTERS-1:0]                     wbm_stb_i,
  input  logic [NUM_MASTERS-1:0]                     wbm_we_i,
  input  logic [NUM_MASTERS*wb_bus_pkg::SEL_W-1:0]   wbm_sel_i,
  input  logic [NUM_MASTERS*wb_bus_pkg::ADR_W-1:0]   wbm_adr_i,
  input  logic [NUM_MASTERS*wb_bus_pkg::DAT_W-1:0]   wbm_dat_i,
  input  logic [NUM_MASTERS-1:0]                     wbm_mask_i,
  output logic [wb_bus_pkg::DAT_W-1:0]               wbm_dat_o,
  output logic [NUM_MASTERS-1:0]                     wbm_ack_o,
  output logic [NUM_MASTERS-1:0]                     wbm_err_o,
  output logic [ID_W-1:0]                            wbm_id_o
);

  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  logic             bus_stb, bus_we;
  logic [SEL_W-1:0] bus_sel;
  logic [ADR_W-1:0] bus_adr;
  logic [DAT_W-1:0] bus_dat;
  logic             sram_stb, reg_stb, sram_ack, reg_ack, dec_err;
  logic [DAT_W-1:0] sram_dat, reg_dat;
  logic [SLV_W-1:0] resp_slave;
  logic             rsp_ack, rsp_err;
  logic [DAT_W-1:0] rsp_dat;

  wbm_arbiter #(.NUM_MASTERS(NUM_MASTERS)) wbm_arbiter_i (
    .wb_clk_i, .wb_rst_i,
    .wbm_cyc_i, .wbm_stb_i, .wbm_we_i, .wbm_sel_i, .wbm_adr_i, .wbm_dat_i, .wbm_mask_i,
    .wbm_dat_o, .wbm_ack_o, .wbm_err_o, .wbm_id_o,
    .bus_stb_o(bus_stb), .bus_we_o(bus_we), .bus_sel_o(bus_sel),
    .bus_adr_o(bus_adr), .bus_dat_o(bus_dat),
    .rsp_ack_i(rsp_ack), .rsp_err_i(rsp_err), .rsp_dat_i(rsp_dat)
  );

  wbs_addr_decoder wbs_addr_decoder_i (
    .wb_clk_i, .wb_rst_i, .bus_stb_i(bus_stb), .bus_adr_i(bus_adr),
    .sram_stb_o(sram_stb), .reg_stb_o(reg_stb),
    .resp_slave_o(resp_slave), .dec_err_o(dec_err)
  );

  wbs_sram #(.SRAM_DEPTH(SRAM_DEPTH)) wbs_sram_i (
    .wb_clk_i, .wb_rst_i, .stb_i(sram_stb), .we_i(bus_we), .sel_i(bus_sel),
    .adr_i(bus_adr), .dat_i(bus_dat), .ack_o(sram_ack), .dat_o(sram_dat)
  );

  wbs_regfile wbs_regfile_i (
    .wb_clk_i, .wb_rst_i, .stb_i(reg_stb), .we_i(bus_we), .sel_i(bus_sel),
    .adr_i(bus_adr), .dat_i(bus_dat), .ack_o(reg_ack), .dat_o(reg_dat)
  );

  wbs_resp_mux wbs_resp_mux_i (
    .resp_slave_i(resp_slave), .dec_err_i(dec_err),
    .sram_ack_i(sram_ack), .sram_dat_i(sram_dat),
    .reg_ack_i(reg_ack), .reg_dat_i(reg_dat),
    .rsp_ack_o(rsp_ack), .rsp_err_o(rsp_err), .rsp_dat_o(rsp_dat)
  );

endmodule

/* tb_wb_subsys.sv */
`timescale 1ns/10ps

module tb_wb_subsys;

  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  localparam int NUM_MASTERS = 4;
  localparam int ID_W = $clog2(NUM_MASTERS);
  localparam int SRAM_DEPTH = 256;
  localparam int N_SRAM = 12;
  localparam int N_RAND = 10;
  // SRAM, registers, unmapped, priority, random traffic and the masked request
  localparam int NUM_XFERS = 3 * N_SRAM + 12 + 2 + NUM_MASTERS + NUM_MASTERS * N_RAND + 1;
  localparam int CYCLE_LIMIT = 40 * NUM_XFERS + 10;

  logic                         wb_clk_i;
  logic                         wb_rst_i;
  logic [NUM_MASTERS-1:0]       wbm_cyc, wbm_stb, wbm_we, wbm_mask, wbm_ack, wbm_err;
  logic [NUM_MASTERS*SEL_W-1:0] wbm_sel;
  logic [NUM_MASTERS*ADR_W-1:0] wbm_adr;
  logic [NUM_MASTERS*DAT_W-1:0] wbm_dat;
  logic [DAT_W-1:0]             wbm_rdat;
  logic [ID_W-1:0]              wbm_id;

  // Open request of each master, and the state of the reference model
  logic             req_open [NUM_MASTERS];
  logic             req_we [NUM_MASTERS];
  logic [SEL_W-1:0] req_sel [NUM_MASTERS];
  logic [ADR_W-1:0] req_adr [NUM_MASTERS];
  logic [DAT_W-1:0] req_dat [NUM_MASTERS];
  logic [DAT_W-1:0] sram_model [SRAM_DEPTH];
  logic [DAT_W-1:0] scratch_model [2];
  logic [DAT_W-1:0] wcount_model;
  int value_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;
  int resp_order [$];
  int sram_words [$];

  wb_subsys_top #(.NUM_MASTERS(NUM_MASTERS), .SRAM_DEPTH(SRAM_DEPTH)) wb_subsys_top_i (
    .wb_clk_i, .wb_rst_i,
    .wbm_cyc_i(wbm_cyc), .wbm_stb_i(wbm_stb), .wbm_we_i(wbm_we), .wbm_sel_i(wbm_sel),
    .wbm_adr_i(wbm_adr), .wbm_dat_i(wbm_dat), .wbm_mask_i(wbm_mask),
    .wbm_dat_o(wbm_rdat), .wbm_ack_o(wbm_ack), .wbm_err_o(wbm_err), .wbm_id_o(wbm_id)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] got);
    $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, expected, got);
    value_errors++;
  endtask

  task automatic flag_problem(input string text);
    $display("Error at %0t: %s", $time, text);
    other_errors++;
  endtask

  function automatic logic [ADR_W-1:0] reg_adr(input logic [REG_OFS_W-1:0] ofs);
    return REG_BASE + (ADR_W'(ofs) << 1);
  endfunction

  // ----------------------------------------
  // Reference model that returns {err, read data}
  // ----------------------------------------
  function automatic logic [DAT_W:0] wb_expect(input logic we, input logic [SEL_W-1:0] sel,
                                              input logic [ADR_W-1:0] adr,
                                              input logic [DAT_W-1:0] dat);
    logic             in_sram;
    logic [DAT_W-1:0] word;
    int               idx;
    in_sram = (adr - SRAM_BASE) < ADR_W'(1 << SRAM_SPAN_BITS);
    idx = int'((adr - SRAM_BASE) >> 1) % SRAM_DEPTH;
    if (in_sram) begin
      word = sram_model[idx];
    end else if ((adr - REG_BASE) < ADR_W'(1 << REG_SPAN_BITS)) begin
      case (adr[1 +: REG_OFS_W])
        REG_SCRATCH0: word = scratch_model[0];
        REG_SCRATCH1: word = scratch_model[1];
        REG_WCOUNT:   word = wcount_model;
        default:      word = ID_VALUE;
      endcase
    end else begin
      return {1'b1, DAT_W'(0)};
    end
    if (we) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel[b]) begin
          word[8*b +: 8] = dat[8*b +: 8];
        end
      end
      if (in_sram) begin
        sram_model[idx] = word;
      end else begin
        // Any write to the register block counts including read-only targets
        wcount_model = wcount_model + DAT_W'(1);
        case (adr[1 +: REG_OFS_W])
          REG_SCRATCH0: scratch_model[0] = word;
          REG_SCRATCH1: scratch_model[1] = word;
          default: ;
        endcase
      end
    end
    return {1'b0, word};
  endfunction

  // One access from master m is held until its ack or err and dropped a cycle later
  task automatic run_xfer(input int m, input logic we, input logic [SEL_W-1:0] sel,
                          input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat,
                          output int waited);
    waited = 0;
    @(posedge wb_clk_i);
    #2;
    req_we[m] = we;
    req_sel[m] = sel;
    req_adr[m] = adr;
    req_dat[m] = dat;
    req_open[m] = 1'b1;
    wbm_we[m] = we;
    wbm_sel[m*SEL_W +: SEL_W] = sel;
    wbm_adr[m*ADR_W +: ADR_W] = adr;
    wbm_dat[m*DAT_W +: DAT_W] = dat;
    wbm_cyc[m] = 1'b1;
    wbm_stb[m] = 1'b1;
    do begin
      @(negedge wb_clk_i);
      waited++;
    end while (!(wbm_ack[m] || wbm_err[m]));
    @(posedge wb_clk_i);
    #2;
    wbm_cyc[m] = 1'b0;
    wbm_stb[m] = 1'b0;
    req_open[m] = 1'b0;
  endtask

  task automatic random_traffic(input int m);
    int               kind;
    int               waited;
    logic [ADR_W-1:0] adr;
    for (int i = 0; i < N_RAND; i++) begin
      kind = $urandom_range(9, 0);
      adr = (kind < 6) ? ADR_W'(sram_words[$urandom_range(N_SRAM - 1, 0)] * 2) :
            (kind < 9) ? reg_adr(REG_OFS_W'($urandom)) : 32'h0003_0000;
      run_xfer(m, 1'($urandom), SEL_W'($urandom), adr, DAT_W'($urandom), waited);
    end
  endtask

  // ----------------------------------------
  // Compare every response with the model
  // ----------------------------------------
  always @(negedge wb_clk_i) begin
    logic [DAT_W:0] expected;
    int             m;
    int             hits;
    if (!wb_rst_i && (|wbm_ack || |wbm_err)) begin
      hits = 0;
      m = 0;
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (wbm_ack[i] || wbm_err[i]) begin
          hits++;
          m = i;
        end
      end
      if (hits != 1) begin
        flag_problem("a response was raised on more than one master");
      end else if (!req_open[m]) begin
        flag_problem($sformatf("master %0d got a response with no request open", m));
      end else begin
        resp_order.push_back(m);
        expected = wb_expect(req_we[m], req_sel[m], req_adr[m], req_dat[m]);
        if (wbm_id !== ID_W'(m)) report_mismatch("wbm_id_o", m, wbm_id);
        if (wbm_err[m] !== expected[DAT_W]) begin
          report_mismatch("wbm_err_o", expected[DAT_W], wbm_err[m]);
        end
        if (wbm_ack[m] !== !expected[DAT_W]) begin
          report_mismatch("wbm_ack_o", !expected[DAT_W], wbm_ack[m]);
        end
        if (!req_we[m] && !expected[DAT_W] && wbm_rdat !== expected[DAT_W-1:0]) begin
          report_mismatch("wbm_dat_o", expected[DAT_W-1:0], wbm_rdat);
        end
      end
    end
  end

  always @(posedge wb_clk_i) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int               waited;
    logic [SEL_W-1:0] sel;
    void'($urandom(85807));
    wb_rst_i = 1'b1;
    wbm_cyc = '0;
    wbm_stb = '0;
    wbm_we = '0;
    wbm_sel = '0;
    wbm_adr = '0;
    wbm_dat = '0;
    wbm_mask = '1;
    scratch_model = '{default: '0};
    wcount_model = '0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      req_open[m] = 1'b0;
    end
    repeat (10) @(posedge wb_clk_i);
    #2;
    wb_rst_i = 1'b0;
    repeat (3) begin
      @(negedge wb_clk_i);
      if (wbm_id !== ID_W'(1)) report_mismatch("wbm_id_o", 1, wbm_id);
      if (wbm_ack !== '0) report_mismatch("wbm_ack_o", 0, wbm_ack);
      if (wbm_err !== '0) report_mismatch("wbm_err_o", 0, wbm_err);
    end

    // Fill, overwrite with random lanes, then read back, all on an idle bus
    for (int pass = 0; pass < 3; pass++) begin
      for (int i = 0; i < N_SRAM; i++) begin
        if (pass == 0) begin
          sram_words.push_back(int'($urandom_range(SRAM_DEPTH - 1, 0)));
        end
        sel = (pass == 0) ? 2'b11 : SEL_W'($urandom);
        run_xfer(0, pass < 2, sel, ADR_W'(sram_words[i] * 2), DAT_W'($urandom), waited);
        // One negedge falls before the capture edge and one after the ack edge
        if (waited - 2 != 2) report_mismatch("ack latency", 2, waited - 2);
      end
    end

    run_xfer(0, 1'b1, 2'b11, reg_adr(REG_SCRATCH0), 16'h1234, waited);
    run_xfer(0, 1'b1, 2'b10, reg_adr(REG_SCRATCH0), 16'hABCD, waited);
    run_xfer(0, 1'b0, 2'b11, reg_adr(REG_SCRATCH0), 16'h0000, waited);
    run_xfer(0, 1'b1, 2'b11, reg_adr(REG_SCRATCH1), 16'h5678, waited);
    run_xfer(0, 1'b1, 2'b01, reg_adr(REG_SCRATCH1), 16'h00EF, waited);
    run_xfer(0, 1'b0, 2'b11, reg_adr(REG_SCRATCH1), 16'h0000, waited);
    run_xfer(0, 1'b0, 2'b11, reg_adr(REG_ID), 16'h0000, waited);
    run_xfer(0, 1'b0, 2'b11, reg_adr(REG_WCOUNT), 16'h0000, waited);
    run_xfer(0, 1'b1, 2'b11, reg_adr(REG_WCOUNT), 16'hFFFF, waited);
    run_xfer(0, 1'b1, 2'b11, reg_adr(REG_ID), 16'h0000, waited);
    run_xfer(0, 1'b0, 2'b11, reg_adr(REG_WCOUNT), 16'h0000, waited);
    run_xfer(0, 1'b0, 2'b11, reg_adr(REG_ID), 16'h0000, waited);

    run_xfer(2, 1'b1, 2'b11, 32'h0002_0000, 16'h5A5A, waited);
    run_xfer(2, 1'b0, 2'b11, 32'h0000_0400, 16'h0000, waited);

    // All masters request in the same cycle and the highest index is served first
    resp_order.delete();
    fork
      run_xfer(0, 1'b0, 2'b11, ADR_W'(sram_words[0] * 2), '0, waited);
      run_xfer(1, 1'b0, 2'b11, ADR_W'(sram_words[1] * 2), '0, waited);
      run_xfer(2, 1'b0, 2'b11, ADR_W'(sram_words[2] * 2), '0, waited);
      run_xfer(3, 1'b0, 2'b11, ADR_W'(sram_words[3] * 2), '0, waited);
    join
    if (resp_order.size() != NUM_MASTERS) begin
      report_mismatch("response count", NUM_MASTERS, resp_order.size());
    end else begin
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (resp_order[i] != NUM_MASTERS - 1 - i) begin
          report_mismatch("response order", NUM_MASTERS - 1 - i, resp_order[i]);
        end
      end
    end

    fork
      random_traffic(0);
      random_traffic(1);
      random_traffic(2);
      random_traffic(3);
    join

    wbm_mask[1] = 1'b0;
    fork
      run_xfer(1, 1'b0, 2'b11, ADR_W'(sram_words[1] * 2), '0, waited);
      begin
        @(posedge wb_clk_i);
        repeat (20) begin
          @(negedge wb_clk_i);
          if (wbm_ack[1] || wbm_err[1]) flag_problem("masked master 1 got a response");
        end
        @(posedge wb_clk_i);
        #2;
        wbm_mask[1] = 1'b1;
      end
    join

    repeat (2) @(negedge wb_clk_i);
    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* flist.f */
wb_bus_pkg.sv
wb_map_pkg.sv
wbm_arbiter.sv
wbs_addr_decoder.sv
wbs_sram.sv
wbs_regfile.sv
wbs_resp_mux.sv
wb_subsys_top.sv
tb_wb_subsys.sv

/* Makefile */
SIM    := verilator
FLAGS  := --binary --timing -Wno-fatal
TOP    := tb_wb_subsys
FLIST  := flist.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := sim.log
PASS   := Simulation passed
SRCS   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
